//--- vlog.f
+incdir+.
scc_bus_pkg.sv
scc_periph_pkg.sv
scc_addr_decode.sv
scc_int_ctrl.sv
scc_timer0.sv
scc_uart_regs.sv
scc_periph_top.sv
tb_scc_periph.sv

//--- tb_scc_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench bus tasks and checks
// CPU access cycles, bounded wait loops and typed compares
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_SCC_TASKS_SVH
`define TB_SCC_TASKS_SVH

// One write cycle in the peripheral space, bus idle afterwards
task automatic bus_write(input scc_bus_pkg::word_addr_t addr, input scc_bus_pkg::data_t data,
                         input logic uds, input logic lds);
    @(posedge clk);
    #1;
    req        = '0;
    req.periph = 1'b1;
    req.addr   = addr;
    req.wdata  = data;
    req.write  = 1'b1;
    req.uds    = uds;
    req.lds    = lds;
    @(posedge clk);
    #1;
    req = '0;
endtask

task automatic bus_read(input scc_bus_pkg::word_addr_t addr, output scc_bus_pkg::data_t data);
    @(posedge clk);
    #1;
    req        = '0;
    req.periph = 1'b1;
    req.addr   = addr;
    req.uds    = 1'b1;
    req.lds    = 1'b1;
    req.fc     = 3'd5;          // Supervisor data
    @(negedge clk);
    data = rdata;
    @(posedge clk);
    #1;
    req = '0;
endtask

// Acknowledge cycle for one level, A3..A1 carry the level
task automatic iack_cycle(input scc_periph_pkg::ipl_t level, output scc_bus_pkg::data_t data,
                          output logic [2:0] acks, output logic avec);
    @(posedge clk);
    #1;
    req      = '0;
    req.addr = {12'hfff, level};
    req.uds  = 1'b1;
    req.lds  = 1'b1;
    req.fc   = scc_bus_pkg::FC_IACK;
    @(negedge clk);
    data = rdata;
    acks = {iack5, iack4, iack2};
    @(posedge clk);
    #1;
    avec = autovector;          // Registered at the edge ending the cycle
    req  = '0;
endtask

task automatic wait_timer_overflow(input int limit);
    scc_bus_pkg::data_t word;
    int                 n;
    n    = 0;
    word = '0;
    while (!word[15] && n < limit) begin
        bus_read(scc_bus_pkg::TIMER_BASE, word);
        n++;
    end
    if (!word[15]) begin
        $display("Timer 0 overflow flag still clear after %0d status reads", limit);
        errors++;
        test_errors++;
    end
endtask

task automatic wait_tx_taken(input int limit);
    int n;
    n = 0;
    while (tx_valid && n < limit) begin
        @(negedge clk);
        n++;
    end
    if (tx_valid) begin
        $display("Transmit byte not taken within %0d cycles of tx_ready", limit);
        errors++;
        test_errors++;
    end
endtask

task automatic check_word(input string name, input scc_bus_pkg::data_t exp,
                          input scc_bus_pkg::data_t act);
    checks++;
    test_checks++;
    if (act !== exp) begin
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
        errors++;
        test_errors++;
    end
endtask

task automatic check_ipl(input string name, input scc_periph_pkg::ipl_t exp,
                         input scc_periph_pkg::ipl_t act);
    checks++;
    test_checks++;
    if (act !== exp) begin
        $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        errors++;
        test_errors++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    test_checks++;
    if (act !== exp) begin
        $display("ERROR %s: expected %b, actual %b", name, exp, act);
        errors++;
        test_errors++;
    end
endtask

task automatic end_test(input string name);
    $display("%-20s %0d checks, %0d errors", name, test_checks, test_errors);
    tests++;
    test_checks = 0;
    test_errors = 0;
endtask

`endif

//--- tb_scc_periph.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the SCC68070 peripheral block
// Plays the CPU and checks registers, interrupts, timer, UART
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_scc_periph;

    typedef struct packed {
        logic int1;
        logic int2;
        logic in2;
        logic in4;
        logic in5;
        logic av;
    } irq_pins_t;

    logic                   clk;
    logic                   reset;
    scc_bus_pkg::bus_req_t  req;
    scc_bus_pkg::data_t     rdata;
    scc_periph_pkg::ipl_t   ipl;
    logic                   autovector;
    logic                   iack2;
    logic                   iack4;
    logic                   iack5;
    irq_pins_t              pins;
    logic [7:0]             tx_data;
    logic                   tx_valid;
    logic                   tx_ready;
    logic [7:0]             rx_data;
    logic                   rx_valid;

    integer                 seed;
    int                     checks;
    int                     errors;
    int                     tests;
    int                     test_checks;
    int                     test_errors;
    int                     i;
    scc_bus_pkg::data_t     wval;
    scc_bus_pkg::data_t     rval;
    scc_periph_pkg::ipl_t   lvl;
    logic [2:0]             acks;
    logic                   avec;
    logic                   ipl_check_on;
    scc_periph_pkg::lir_t   lir_model;      // Levels as last written
    scc_periph_pkg::picr1_t picr1_model;

    `include "tb_scc_tasks.svh"

    scc_periph_top dut (
        .clk(clk), .reset(reset), .req(req), .rdata(rdata),
        .ipl(ipl), .autovector(autovector), .iack2(iack2), .iack4(iack4), .iack5(iack5),
        .int1(pins.int1), .int2(pins.int2), .in2(pins.in2), .in4(pins.in4),
        .in5(pins.in5), .av(pins.av),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .rx_data(rx_data), .rx_valid(rx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Highest source first, on-chip sources need a nonzero level
    function automatic scc_periph_pkg::ipl_t expected_ipl(input irq_pins_t p,
            input scc_periph_pkg::lir_t l, input scc_periph_pkg::picr1_t p1, input logic ov);
        if (ov && p1.timer_ipl != 3'd0) return p1.timer_ipl;
        if (p.int2 && l.int2_ipl != 3'd0) return l.int2_ipl;
        if (p.int1 && l.int1_ipl != 3'd0) return l.int1_ipl;
        if (p.in5) return 3'd5;
        if (p.in4) return 3'd4;
        if (p.in2) return 3'd2;
        return 3'd0;
    endfunction

    task automatic drive_pins(input irq_pins_t value);
        @(posedge clk);
        #1;
        pins = value;
    endtask

    // Levels sit in bits 6:4 and 2:0 and read back in both bytes
    task automatic check_level_reg(input string name, input scc_bus_pkg::word_addr_t addr);
        scc_bus_pkg::data_t value;
        scc_bus_pkg::data_t word;
        value = $random(seed);
        bus_write(addr, value, 1'b1, 1'b1);
        bus_read(addr, word);
        check_word(name, {2{value[7:0] & 8'h77}}, word);
    endtask

    // Timer overflow stays clear during the priority test
    always @(negedge clk) begin
        if (ipl_check_on) begin
            check_ipl("interrupt priority", expected_ipl(pins, lir_model, picr1_model, 1'b0), ipl);
        end
    end

    initial begin
        seed         = 32'h497;
        reset        = 1'b1;
        req          = '0;
        pins         = '0;
        tx_ready     = 1'b0;
        rx_data      = 8'h00;
        rx_valid     = 1'b0;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        test_checks  = 0;
        test_errors  = 0;
        ipl_check_on = 1'b0;
        lir_model    = '0;
        picr1_model  = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        for (i = 0; i < 8; i++) begin
            check_level_reg("lir readback", scc_bus_pkg::LIR_ADDR);
            check_level_reg("picr1 readback", scc_bus_pkg::PICR1_ADDR);
            check_level_reg("picr2 readback", scc_bus_pkg::PICR2_ADDR);
            wval = $random(seed);
            bus_write(scc_bus_pkg::TIMER_BASE + 15'd1, wval, 1'b1, 1'b1);
            bus_read(scc_bus_pkg::TIMER_BASE + 15'd1, rval);
            check_word("reload readback", wval, rval);
        end
        end_test("register readback");

        ipl_check_on = 1'b1;
        for (i = 0; i < 40; i++) begin
            wval = $random(seed);
            bus_write(scc_bus_pkg::LIR_ADDR, wval, 1'b1, 1'b1);
            lir_model = {wval[6:4], wval[2:0]};
            wval = $random(seed);
            bus_write(scc_bus_pkg::PICR1_ADDR, wval, 1'b1, 1'b1);
            picr1_model = {wval[6:4], wval[2:0]};
            wval = $random(seed);
            drive_pins(irq_pins_t'(wval[5:0]));
            @(posedge clk);
        end
        ipl_check_on = 1'b0;
        drive_pins('0);
        end_test("interrupt priority");

        // int1 at a random nonzero level, vector comes from the chip
        wval = $random(seed);
        lvl  = (wval[2:0] == 3'd0) ? 3'd3 : wval[2:0];
        bus_write(scc_bus_pkg::LIR_ADDR, {8'h00, 1'b0, lvl, 4'h0}, 1'b1, 1'b1);
        drive_pins(6'b100000);
        @(negedge clk);
        check_ipl("int1 level", lvl, ipl);
        iack_cycle(lvl, rval, acks, avec);
        check_word("on-chip vector", scc_bus_pkg::VECTOR_BASE + lvl, rval);
        check_bit("on-chip autovector", 1'b0, avec);
        drive_pins({4'b0001, 1'b0, wval[8]});
        @(negedge clk);
        check_ipl("in4 level", 3'd4, ipl);
        iack_cycle(3'd4, rval, acks, avec);
        check_bit("iack4", 1'b1, acks[1]);
        check_bit("iack2 or iack5", 1'b0, acks[0] | acks[2]);
        check_word("no vector for in4", 16'h0000, rval);
        check_bit("external autovector", wval[8], avec);
        drive_pins('0);
        end_test("acknowledge cycle");

        wval     = $random(seed);
        wval[15] = 1'b0;        // Reload well below the top
        bus_write(scc_bus_pkg::TIMER_BASE + 15'd1, wval, 1'b1, 1'b1);
        bus_write(scc_bus_pkg::TIMER_BASE + 15'd2, 16'hfffe, 1'b1, 1'b1);
        wait_timer_overflow(200);
        bus_read(scc_bus_pkg::TIMER_BASE + 15'd2, rval);
        check_word("count after overflow", wval, rval);
        // Timer source raises its programmed level while the flag is set
        bus_write(scc_bus_pkg::PICR1_ADDR, 16'h0006, 1'b0, 1'b1);
        picr1_model = {3'd0, 3'd6};
        @(negedge clk);
        check_ipl("timer level", expected_ipl('0, lir_model, picr1_model, 1'b1), ipl);
        bus_write(scc_bus_pkg::TIMER_BASE, 16'h8000, 1'b1, 1'b0);
        bus_read(scc_bus_pkg::TIMER_BASE, rval);
        check_word("overflow cleared", 16'h0000, rval);
        @(negedge clk);
        check_ipl("timer level cleared", expected_ipl('0, lir_model, picr1_model, 1'b0), ipl);
        end_test("timer 0");

        wval = $random(seed);
        bus_write(scc_bus_pkg::UART_BASE + 15'd4, wval, 1'b0, 1'b1);
        check_word("tx byte", {8'h00, wval[7:0]}, {8'h00, tx_data});
        repeat (3) begin
            @(negedge clk);
            check_bit("tx_valid held", 1'b1, tx_valid);
        end
        @(posedge clk);
        #1;
        tx_ready = 1'b1;
        wait_tx_taken(20);
        @(posedge clk);
        #1;
        tx_ready = 1'b0;
        rx_data  = wval[15:8];
        rx_valid = 1'b1;
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
        bus_read(scc_bus_pkg::UART_BASE + 15'd1, rval);
        check_word("status rx_rdy set", 16'h0005, rval);
        bus_read(scc_bus_pkg::UART_BASE + 15'd5, rval);
        check_word("rx byte", {8'h00, wval[15:8]}, rval);
        bus_read(scc_bus_pkg::UART_BASE + 15'd1, rval);
        check_word("status rx_rdy clear", 16'h0004, rval);
        end_test("uart");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- scc_periph_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCC68070 on-chip peripherals
// Decoder, interrupt controller, timer 0 and UART registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module scc_periph_top (
    input  logic                  clk,
    input  logic                  reset,

    // CPU side
    input  scc_bus_pkg::bus_req_t req,
    output scc_bus_pkg::data_t    rdata,

    // Interrupts
    output scc_periph_pkg::ipl_t  ipl,
    output logic                  autovector,
    output logic                  iack2,
    output logic                  iack4,
    output logic                  iack5,
    input  logic                  int1,
    input  logic                  int2,
    input  logic                  in2,
    input  logic                  in4,
    input  logic                  in5,
    input  logic                  av,

    // Serializer link
    output logic [7:0]            tx_data,
    output logic                  tx_valid,
    input  logic                  tx_ready,
    input  logic [7:0]            rx_data,
    input  logic                  rx_valid
);

    scc_bus_pkg::block_sel_t       sel;
    scc_periph_pkg::lir_t          lir;
    scc_periph_pkg::picr1_t        picr1;
    scc_periph_pkg::picr2_t        picr2;
    scc_periph_pkg::timer_status_t tmr_status;
    scc_bus_pkg::data_t            tmr_reload;
    scc_bus_pkg::data_t            tmr_count;
    scc_periph_pkg::uart_status_t  uart_status;
    logic [7:0]                    uart_rhr;
    logic                          t0_ov;
    logic                          vector_drive;

    scc_addr_decode u_decode (
        .req(req), .sel(sel),
        .lir(lir), .picr1(picr1), .picr2(picr2),
        .tmr_status(tmr_status), .tmr_reload(tmr_reload), .tmr_count(tmr_count),
        .uart_status(uart_status), .uart_rhr(uart_rhr),
        .vector_drive(vector_drive), .rdata(rdata)
    );

    scc_int_ctrl u_int_ctrl (
        .clk(clk), .reset(reset), .req(req),
        .sel_lir(sel.lir), .sel_picr1(sel.picr1), .sel_picr2(sel.picr2),
        .int1(int1), .int2(int2), .in2(in2), .in4(in4), .in5(in5), .av(av),
        .t0_ov(t0_ov),
        .lir(lir), .picr1(picr1), .picr2(picr2),
        .ipl(ipl), .autovector(autovector), .vector_drive(vector_drive),
        .iack2(iack2), .iack4(iack4), .iack5(iack5)
    );

    scc_timer0 u_timer0 (
        .clk(clk), .reset(reset), .req(req),
        .sel_timer(sel.timer), .reg_idx(sel.reg_idx),
        .t0_ov(t0_ov), .status(tmr_status),
        .reload(tmr_reload), .count(tmr_count)
    );

    scc_uart_regs u_uart (
        .clk(clk), .reset(reset), .req(req),
        .sel_uart(sel.uart), .reg_idx(sel.reg_idx),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .rx_data(rx_data), .rx_valid(rx_valid),
        .status(uart_status), .rhr(uart_rhr)
    );

endmodule

`default_nettype wire

//--- scc_uart_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART register file
// Status and holding registers with a byte link
// to an external serializer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module scc_uart_regs (
    input  logic                         clk,
    input  logic                         reset,
    input  scc_bus_pkg::bus_req_t        req,
    input  logic                         sel_uart,
    input  logic [2:0]                   reg_idx,

    // Transmit side
    output logic [7:0]                   tx_data,
    output logic                         tx_valid,
    input  logic                         tx_ready,

    // Receive side
    input  logic [7:0]                   rx_data,
    input  logic                         rx_valid,

    output scc_periph_pkg::uart_status_t status,
    output logic [7:0]                   rhr
);

    logic rx_rdy;
    logic wr_low;
    logic rd_low;

    assign wr_low = sel_uart && req.lds && req.write;
    assign rd_low = sel_uart && req.lds && !req.write;

    // Transmit holding register
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_data  <= '0;
            tx_valid <= 1'b0;
        end else if (wr_low && reg_idx == scc_periph_pkg::UART_REG_THR) begin
            tx_data  <= req.wdata[7:0];    // Overwrites a pending byte
            tx_valid <= 1'b1;
        end else if (tx_valid && tx_ready) begin
            tx_valid <= 1'b0;              // Taken by the serializer
        end
    end

    // Receive holding register
    always_ff @(posedge clk) begin
        if (reset) begin
            rhr    <= '0;
            rx_rdy <= 1'b0;
        end else if (rx_valid) begin
            rhr    <= rx_data;             // New byte wins over a read
            rx_rdy <= 1'b1;
        end else if (rd_low && reg_idx == scc_periph_pkg::UART_REG_RHR) begin
            rx_rdy <= 1'b0;
        end
    end

    always_comb begin
        status        = '0;
        status.rx_rdy = rx_rdy;
        status.tx_rdy = !tx_valid;
        status.tx_emt = tx_ready;
    end

endmodule

`default_nettype wire

//--- scc_timer0.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer 0
// Prescaled up counter with reload and overflow flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module scc_timer0 (
    input  logic                          clk,
    input  logic                          reset,
    input  scc_bus_pkg::bus_req_t         req,
    input  logic                          sel_timer,
    input  logic [2:0]                    reg_idx,
    output logic                          t0_ov,
    output scc_periph_pkg::timer_status_t status,
    output scc_bus_pkg::data_t            reload,
    output scc_bus_pkg::data_t            count
);

    logic [7:0] prescale;
    logic       wr;
    logic       at_top;
    logic       load;
    logic       ov_clear;

    assign wr       = sel_timer && req.write;
    assign at_top   = count == 16'hffff;
    assign load     = wr && (req.uds || req.lds) && reg_idx == scc_periph_pkg::TIMER_REG_T0;
    // Write one to clear, upper byte only
    assign ov_clear = wr && req.uds && reg_idx == scc_periph_pkg::TIMER_REG_CTRL
                      && req.wdata[15];

    always_ff @(posedge clk) begin
        if (reset) begin
            t0_ov <= 1'b0;
        end else if (at_top) begin
            t0_ov <= 1'b1;      // Overflow beats the clear
        end else if (ov_clear) begin
            t0_ov <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count    <= '0;
            prescale <= '0;
        end else if (at_top) begin
            count    <= reload;
            prescale <= '0;
        end else if (load) begin
            if (req.uds) count[15:8] <= req.wdata[15:8];
            if (req.lds) count[7:0]  <= req.wdata[7:0];
            prescale <= '0;
        end else if (prescale == scc_periph_pkg::TICKS_PER_COUNT - 8'd1) begin
            count    <= count + 16'd1;
            prescale <= '0;
        end else begin
            prescale <= prescale + 8'd1;
        end
    end

    // Reload register, byte writable
    always_ff @(posedge clk) begin
        if (reset) begin
            reload <= '0;
        end else if (wr && reg_idx == scc_periph_pkg::TIMER_REG_RELOAD) begin
            if (req.uds) reload[15:8] <= req.wdata[15:8];
            if (req.lds) reload[7:0]  <= req.wdata[7:0];
        end
    end

    always_comb begin
        status       = '0;     // Timers 1 and 2 not present
        status.t0_ov = t0_ov;
    end

endmodule

`default_nettype wire

//--- scc_int_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interrupt controller
// LIR and PICR registers, IPL resolution, autovector flag
// and the decoded acknowledge outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module scc_int_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  scc_bus_pkg::bus_req_t  req,
    input  logic                   sel_lir,
    input  logic                   sel_picr1,
    input  logic                   sel_picr2,

    input  logic                   int1,    // Latched inputs, level from LIR
    input  logic                   int2,
    input  logic                   in2,     // Fixed level inputs
    input  logic                   in4,
    input  logic                   in5,
    input  logic                   av,
    input  logic                   t0_ov,

    output scc_periph_pkg::lir_t   lir,
    output scc_periph_pkg::picr1_t picr1,
    output scc_periph_pkg::picr2_t picr2,
    output scc_periph_pkg::ipl_t   ipl,
    output logic                   autovector,
    output logic                   vector_drive,
    output logic                   iack2,
    output logic                   iack4,
    output logic                   iack5
);

    logic                 irq_ack;
    scc_periph_pkg::ipl_t ack_ipl;
    logic [7:0]           autovector_lut;   // Autovector flag per level
    logic                 on_chip;
    logic                 wr_low;

    assign irq_ack = req.fc == scc_bus_pkg::FC_IACK;
    assign ack_ipl = req.addr[2:0];
    assign wr_low  = req.write && req.lds;

    always_ff @(posedge clk) begin
        if (reset) begin
            lir   <= '0;
            picr1 <= '0;
            picr2 <= '0;
        end else begin
            if (sel_lir && wr_low) begin
                lir.int1_ipl <= req.wdata[6:4];
                lir.int2_ipl <= req.wdata[2:0];
            end
            if (sel_picr1 && wr_low) begin
                picr1.i2c_ipl   <= req.wdata[6:4];
                picr1.timer_ipl <= req.wdata[2:0];
            end
            if (sel_picr2 && wr_low) begin
                picr2.uart_rx_ipl <= req.wdata[6:4];
                picr2.uart_tx_ipl <= req.wdata[2:0];
            end
        end
    end

    // Later sources override earlier ones
    always_comb begin
        ipl            = '0;
        autovector_lut = 8'hff;
        on_chip        = 1'b0;

        if (in2) ipl = 3'd2;
        if (in4) begin
            ipl = 3'd4;
            autovector_lut[4] = av;     // External device chooses
        end
        if (in5) ipl = 3'd5;
        if (int1 && lir.int1_ipl != 3'd0) begin
            ipl = lir.int1_ipl;
            autovector_lut[ipl] = 1'b0;
            on_chip = 1'b1;
        end
        if (int2 && lir.int2_ipl != 3'd0) begin
            ipl = lir.int2_ipl;
            autovector_lut[ipl] = 1'b0;
            on_chip = 1'b1;
        end
        if (t0_ov && picr1.timer_ipl != 3'd0) begin
            ipl = picr1.timer_ipl;
            autovector_lut[ipl] = 1'b0;
            on_chip = 1'b1;
        end
    end

    assign vector_drive = on_chip && irq_ack;

    always_ff @(posedge clk) begin
        if (reset) autovector <= 1'b0;
        else       autovector <= irq_ack && autovector_lut[ack_ipl];   // IACK cycles only
    end

    assign iack2 = in2 && irq_ack && ack_ipl == 3'd2;
    assign iack4 = in4 && irq_ack && ack_ipl == 3'd4;
    assign iack5 = in5 && irq_ack && ack_ipl == 3'd5;

endmodule

`default_nettype wire

//--- scc_addr_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral address decoder and read multiplexer
// Forms block selects from the word address and builds
// the read word, with the on-chip vector during IACK
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module scc_addr_decode (
    input  scc_bus_pkg::bus_req_t         req,
    output scc_bus_pkg::block_sel_t       sel,

    // Register views
    input  scc_periph_pkg::lir_t          lir,
    input  scc_periph_pkg::picr1_t        picr1,
    input  scc_periph_pkg::picr2_t        picr2,
    input  scc_periph_pkg::timer_status_t tmr_status,
    input  scc_bus_pkg::data_t            tmr_reload,
    input  scc_bus_pkg::data_t            tmr_count,
    input  scc_periph_pkg::uart_status_t  uart_status,
    input  logic [7:0]                    uart_rhr,

    input  logic                          vector_drive,
    output scc_bus_pkg::data_t            rdata
);

    logic [2:0] idx;

    assign idx = req.addr[2:0];

    always_comb begin
        sel.lir     = req.periph && req.addr == scc_bus_pkg::LIR_ADDR;
        sel.picr1   = req.periph && req.addr == scc_bus_pkg::PICR1_ADDR;
        sel.picr2   = req.periph && req.addr == scc_bus_pkg::PICR2_ADDR;
        sel.timer   = req.periph && req.addr >= scc_bus_pkg::TIMER_BASE
                                 && req.addr <= scc_bus_pkg::TIMER_LAST;
        sel.uart    = req.periph && req.addr >= scc_bus_pkg::UART_BASE
                                 && req.addr <= scc_bus_pkg::UART_LAST;
        sel.reg_idx = idx;
    end

    always_comb begin
        rdata = '0;

        if (sel.lir) begin
            // Same byte on both halves
            rdata = {2{1'b0, lir.int1_ipl, 1'b0, lir.int2_ipl}};
        end else if (sel.picr1) begin
            rdata = {2{1'b0, picr1.i2c_ipl, 1'b0, picr1.timer_ipl}};
        end else if (sel.picr2) begin
            rdata = {2{1'b0, picr2.uart_rx_ipl, 1'b0, picr2.uart_tx_ipl}};
        end else if (sel.timer) begin
            case (idx)
                scc_periph_pkg::TIMER_REG_CTRL:   rdata = {tmr_status, 8'h00}; // Control reads 0
                scc_periph_pkg::TIMER_REG_RELOAD: rdata = tmr_reload;
                scc_periph_pkg::TIMER_REG_T0:     rdata = tmr_count;
                default:                          rdata = '0;  // Timers 1 and 2 absent
            endcase
        end else if (sel.uart) begin
            case (idx)
                scc_periph_pkg::UART_REG_STATUS: rdata = {8'h00, uart_status};
                scc_periph_pkg::UART_REG_RHR:    rdata = {8'h00, uart_rhr};
                default:                         rdata = '0;
            endcase
        end

        // On-chip source being acknowledged supplies its own vector
        if (vector_drive) begin
            rdata = scc_bus_pkg::VECTOR_BASE + {13'd0, idx};
        end
    end

endmodule

`default_nettype wire

//--- scc_periph_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCC68070 peripheral register layouts
// Interrupt, timer and UART register contents and indices
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package scc_periph_pkg;

    typedef logic [2:0] ipl_t;

    typedef struct packed {
        ipl_t int1_ipl;
        ipl_t int2_ipl;
    } lir_t;

    typedef struct packed {
        ipl_t i2c_ipl;
        ipl_t timer_ipl;
    } picr1_t;

    typedef struct packed {
        ipl_t uart_rx_ipl;
        ipl_t uart_tx_ipl;
    } picr2_t;

    // Upper byte of timer register 0
    typedef struct packed {
        logic t0_ov;
        logic t1_ma;
        logic t1_cap;
        logic t1_ov;
        logic t2_ma;
        logic t2_cap;
        logic t2_ov;
        logic reserved;
    } timer_status_t;

    typedef struct packed {
        logic received_break;
        logic framing_error;
        logic parity_error;
        logic overrun_error;
        logic tx_emt;
        logic tx_rdy;
        logic reserved;
        logic rx_rdy;
    } uart_status_t;

    typedef struct packed {
        logic [1:0] channel_mode;
        logic       reserved;
        logic       ctsn_enable;
        logic       parity_control;
        logic       parity_type;
        logic       stop_bit_length;
        logic       character_length;
    } uart_mode_t;

    localparam logic [7:0] TICKS_PER_COUNT = 8'd192;   // Prescaler period

    localparam logic [2:0] TIMER_REG_CTRL   = 3'd0;
    localparam logic [2:0] TIMER_REG_RELOAD = 3'd1;
    localparam logic [2:0] TIMER_REG_T0     = 3'd2;

    localparam logic [2:0] UART_REG_MODE   = 3'd0;
    localparam logic [2:0] UART_REG_STATUS = 3'd1;
    localparam logic [2:0] UART_REG_THR    = 3'd4;
    localparam logic [2:0] UART_REG_RHR    = 3'd5;

endpackage

`default_nettype wire

//--- scc_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCC68070 peripheral bus definitions
// Per-cycle CPU request, block selects and the on-chip
// address map of the peripheral space
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package scc_bus_pkg;

    typedef logic [15:0] data_t;
    typedef logic [14:0] word_addr_t;   // A15..A1

    // One CPU access cycle as seen by the peripherals
    typedef struct packed {
        logic       periph;     // Address bit 31, on-chip space
        word_addr_t addr;
        data_t      wdata;
        logic       write;
        logic       uds;        // Upper byte strobe
        logic       lds;        // Lower byte strobe
        logic [2:0] fc;         // Function code
    } bus_req_t;

    typedef struct packed {
        logic       lir;
        logic       picr1;
        logic       picr2;
        logic       timer;
        logic       uart;
        logic [2:0] reg_idx;    // A3..A1 inside the window
    } block_sel_t;

    // Single word registers
    localparam word_addr_t LIR_ADDR   = 15'h0800;
    localparam word_addr_t PICR1_ADDR = 15'h1022;
    localparam word_addr_t PICR2_ADDR = 15'h1023;

    // Register windows, both ends inclusive
    localparam word_addr_t TIMER_BASE = 15'h1010;
    localparam word_addr_t TIMER_LAST = 15'h1014;
    localparam word_addr_t UART_BASE  = 15'h1008;
    localparam word_addr_t UART_LAST  = 15'h100D;

    // Interrupt acknowledge space
    localparam logic [2:0] FC_IACK = 3'd7;

    // On-chip vectors start here, one per level
    localparam data_t VECTOR_BASE = 16'd56;

endpackage

`default_nettype wire
